/* include/cache_bus_macros.svh */
`ifndef CACHE_BUS_MACROS_SVH
`define CACHE_BUS_MACROS_SVH

// number of cache ports sharing the axi master
`define CACHE_PORT_NUM 2

// cache bus and axi data width
`define CACHE_DATA_W 32

// byte address width
`define CACHE_ADDR_W 32

// axi len for a cache line burst, 3 means 4 beats
// single transfers use len 0
`define AXI_BURST_LEN 3

`endif

/* verilog/cache_bus_pkg.sv */
`include "cache_bus_macros.svh"

package cache_bus_pkg;

	localparam int STRB_W = `CACHE_DATA_W / 8;

	// fixed axi attributes
	localparam logic [2:0] AXI_SIZE = 3'($clog2(STRB_W)); // full bus width beats
	localparam logic [1:0] AXI_BURST_WRAP = 2'b10;
	localparam logic [2:0] AXI_PROT = 3'b001;              // privileged data access
	localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

	// converter fsm, one hot
	typedef enum logic [3:0] {
		ST_IDLE = 4'b0001,
		ST_ADDR = 4'b0010,
		ST_DATA = 4'b0100,
		ST_RESP = 4'b1000
	} bridge_state_t;

	// request latched on grant
	typedef struct packed {
		logic write;
		logic burst;
		logic cached;
		logic [`CACHE_ADDR_W-1:0] addr;
	} cache_req_info_t;

	// one write beat on its way to the W channel
	typedef struct packed {
		logic last;
		logic [STRB_W-1:0] strb;
		logic [`CACHE_DATA_W-1:0] data;
	} wbeat_t;

endpackage

/* verilog/rr_arbiter.sv */
`timescale 1ns/1ps
`include "cache_bus_macros.svh"

module rr_arbiter #(
	parameter int REQ_NUM = `CACHE_PORT_NUM
)(
	input  logic clk,
	input  logic rst_n,
	input  logic [REQ_NUM-1:0] req_i,
	input  logic take_i,
	output logic [REQ_NUM-1:0] sel_o
);

	localparam int PTR_W = (REQ_NUM > 1) ? $clog2(REQ_NUM) : 1;

	logic [PTR_W-1:0] ptr_q;     // highest priority port
	logic [PTR_W-1:0] grant_idx;

	// first requester at or after the pointer
	always_comb begin
		int idx;
		logic found;
		sel_o = '0;
		grant_idx = ptr_q;
		found = 1'b0;
		for (int k = 0; k < REQ_NUM; k++) begin
			idx = (int'(ptr_q) + k) % REQ_NUM;
			if (!found && req_i[idx]) begin
				sel_o[idx] = 1'b1;
				grant_idx = PTR_W'(idx);
				found = 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (~rst_n) begin
			ptr_q <= '0;
		end else if (take_i && |sel_o) begin
			// step past the winner so a busy port cannot starve the others
			if (grant_idx == PTR_W'(REQ_NUM - 1)) begin
				ptr_q <= '0;
			end else begin
				ptr_q <= grant_idx + 1'b1;
			end
		end
	end

endmodule

/* verilog/axi_wbeat_stage.sv */
`timescale 1ns/1ps
`include "cache_bus_macros.svh"

module axi_wbeat_stage
	import cache_bus_pkg::*;
(
	input  logic clk,
	input  logic rst_n,
	// cache side
	input  logic in_valid_i,
	output logic in_ready_o,
	input  wbeat_t in_beat_i,
	// axi W channel
	output logic wvalid_o,
	input  logic wready_i,
	output logic [`CACHE_DATA_W-1:0] wdata_o,
	output logic [STRB_W-1:0] wstrb_o,
	output logic wlast_o
);

	logic full_q;
	wbeat_t beat_q;

	// empty, or the held beat leaves this cycle
	assign in_ready_o = ~full_q | wready_i;

	always_ff @(posedge clk) begin
		if (~rst_n) begin
			full_q <= 1'b0;
		end else if (in_ready_o) begin
			full_q <= in_valid_i;
		end
	end

	always_ff @(posedge clk) begin
		if (in_ready_o && in_valid_i) begin
			beat_q <= in_beat_i; // reload behind a departing beat
		end
	end

	assign wvalid_o = full_q;
	assign wdata_o = beat_q.data;
	assign wstrb_o = beat_q.strb;
	assign wlast_o = beat_q.last;

endmodule

/* verilog/axi_converter.sv */
`timescale 1ns/1ps
`include "cache_bus_macros.svh"

module axi_converter
	import cache_bus_pkg::*;
#(
	parameter int PORT_NUM = `CACHE_PORT_NUM
)(
	input  logic clk,
	input  logic rst_n,
	// cache ports
	input  logic [PORT_NUM-1:0] req_valid_i,
	input  logic [PORT_NUM-1:0] req_write_i,
	input  logic [PORT_NUM-1:0] req_burst_i,
	input  logic [PORT_NUM-1:0] req_cached_i,
	input  logic [PORT_NUM-1:0][`CACHE_ADDR_W-1:0] req_addr_i,
	input  logic [PORT_NUM-1:0] wdata_ok_i,
	input  logic [PORT_NUM-1:0] wdata_last_i,
	input  logic [PORT_NUM-1:0][STRB_W-1:0] wstrb_i,
	input  logic [PORT_NUM-1:0][`CACHE_DATA_W-1:0] wdata_i,
	output logic [PORT_NUM-1:0] req_ready_o,
	output logic [PORT_NUM-1:0] data_ok_o,
	output logic [PORT_NUM-1:0] data_last_o,
	output logic [PORT_NUM-1:0][`CACHE_DATA_W-1:0] rdata_o,
	output logic [PORT_NUM-1:0][1:0] resp_o,
	// arbiter
	input  logic [PORT_NUM-1:0] arb_sel_i,
	output logic take_o,
	// write-beat stage
	output logic wb_valid_o,
	input  logic wb_ready_i,
	output wbeat_t wb_beat_o,
	// AR
	output logic [`CACHE_ADDR_W-1:0] araddr_o,
	output logic [7:0] arlen_o,
	output logic [2:0] arsize_o,
	output logic [1:0] arburst_o,
	output logic [3:0] arcache_o,
	output logic [2:0] arprot_o,
	output logic arvalid_o,
	input  logic arready_i,
	// AW
	output logic [`CACHE_ADDR_W-1:0] awaddr_o,
	output logic [7:0] awlen_o,
	output logic [2:0] awsize_o,
	output logic [1:0] awburst_o,
	output logic [3:0] awcache_o,
	output logic [2:0] awprot_o,
	output logic awvalid_o,
	input  logic awready_i,
	// R
	input  logic [`CACHE_DATA_W-1:0] rdata_i,
	input  logic [1:0] rresp_i,
	input  logic rlast_i,
	input  logic rvalid_i,
	output logic rready_o,
	// B
	input  logic [1:0] bresp_i,
	input  logic bvalid_i,
	output logic bready_o
);

	bridge_state_t state_q, state_d;
	cache_req_info_t req_d, req_q;
	logic [PORT_NUM-1:0] grant;
	logic [PORT_NUM-1:0] sel_q;  // owner of the current transaction
	logic addr_done;
	logic rd_beat;
	logic wr_open;
	logic wr_done;
	logic [7:0] ax_len;
	logic [3:0] ax_cache;

	assign take_o = (state_q == ST_IDLE);
	assign grant = arb_sel_i & req_valid_i;
	assign req_ready_o = grant & {PORT_NUM{take_o}};

	always_comb begin
		req_d = '0;
		for (int i = 0; i < PORT_NUM; i++) begin
			if (grant[i]) begin
				req_d.write = req_write_i[i];
				req_d.burst = req_burst_i[i];
				req_d.cached = req_cached_i[i];
				req_d.addr = req_addr_i[i];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (take_o && |grant) begin
			req_q <= req_d;
		end
	end

	always_ff @(posedge clk) begin
		if (~rst_n) begin
			sel_q <= '0;
		end else if (take_o) begin
			sel_q <= grant;
		end
	end

	assign addr_done = req_q.write ? awready_i : arready_i;
	assign rd_beat = (state_q == ST_DATA) & ~req_q.write & rvalid_i & rready_o;
	assign wr_open = (state_q == ST_DATA) & req_q.write;
	// last beat handed to the W stage, B cannot come before it drains
	assign wr_done = wb_valid_o & wb_ready_i & wb_beat_o.last;

	always_comb begin
		state_d = state_q;
		case (state_q)
			ST_IDLE: begin
				if (|grant) begin
					state_d = ST_ADDR;
				end
			end
			ST_ADDR: begin
				if (addr_done) begin
					state_d = ST_DATA;
				end
			end
			ST_DATA: begin
				if (rd_beat && rlast_i) begin
					state_d = ST_IDLE;
				end else if (wr_done) begin
					state_d = ST_RESP;
				end
			end
			ST_RESP: begin
				if (bvalid_i && bready_o) begin
					state_d = ST_IDLE;
				end
			end
			default: state_d = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (~rst_n) begin
			state_q <= ST_IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	// write beats from the owning port
	always_comb begin
		wb_beat_o = '0;
		wb_valid_o = 1'b0;
		for (int i = 0; i < PORT_NUM; i++) begin
			if (sel_q[i]) begin
				wb_valid_o = wr_open & wdata_ok_i[i];
				wb_beat_o.last = wdata_last_i[i];
				wb_beat_o.strb = wstrb_i[i];
				wb_beat_o.data = wdata_i[i];
			end
		end
	end

	for (genvar i = 0; i < PORT_NUM; i++) begin : g_port
		assign data_ok_o[i] = sel_q[i] & (rd_beat | (wr_open & wb_ready_i));
		assign data_last_o[i] = sel_q[i] & rd_beat & rlast_i;
		assign rdata_o[i] = rdata_i;
		assign resp_o[i] = bready_o ? bresp_i : rresp_i; // bresp during resp state
	end

	assign ax_len = req_q.burst ? 8'(`AXI_BURST_LEN) : 8'd0;
	assign ax_cache = {2'b00, req_q.cached, 1'b0}; // modifiable when cacheable

	assign araddr_o = req_q.addr;
	assign arlen_o = ax_len;
	assign arsize_o = AXI_SIZE;
	assign arburst_o = AXI_BURST_WRAP;
	assign arcache_o = ax_cache;
	assign arprot_o = AXI_PROT;
	assign arvalid_o = (state_q == ST_ADDR) & ~req_q.write;

	assign awaddr_o = req_q.addr;
	assign awlen_o = ax_len;
	assign awsize_o = AXI_SIZE;
	assign awburst_o = AXI_BURST_WRAP;
	assign awcache_o = ax_cache;
	assign awprot_o = AXI_PROT;
	assign awvalid_o = (state_q == ST_ADDR) & req_q.write;

	assign rready_o = 1'b1; // caches always sink read beats
	assign bready_o = (state_q == ST_RESP);

endmodule

/* verilog/cache_axi_top.sv */
`timescale 1ns/1ps
`include "cache_bus_macros.svh"

module cache_axi_top
	import cache_bus_pkg::*;
#(
	parameter int PORT_NUM = `CACHE_PORT_NUM
)(
	input  logic clk,
	input  logic rst_n,
	// cache ports
	input  logic [PORT_NUM-1:0] req_valid_i,
	input  logic [PORT_NUM-1:0] req_write_i,
	input  logic [PORT_NUM-1:0] req_burst_i,
	input  logic [PORT_NUM-1:0] req_cached_i,
	input  logic [PORT_NUM-1:0][`CACHE_ADDR_W-1:0] req_addr_i,
	input  logic [PORT_NUM-1:0] wdata_ok_i,
	input  logic [PORT_NUM-1:0] wdata_last_i,
	input  logic [PORT_NUM-1:0][STRB_W-1:0] wstrb_i,
	input  logic [PORT_NUM-1:0][`CACHE_DATA_W-1:0] wdata_i,
	output logic [PORT_NUM-1:0] req_ready_o,
	output logic [PORT_NUM-1:0] data_ok_o,
	output logic [PORT_NUM-1:0] data_last_o,
	output logic [PORT_NUM-1:0][`CACHE_DATA_W-1:0] rdata_o,
	output logic [PORT_NUM-1:0][1:0] resp_o,
	// axi master
	output logic [`CACHE_ADDR_W-1:0] araddr_o,
	output logic [7:0] arlen_o,
	output logic [2:0] arsize_o,
	output logic [1:0] arburst_o,
	output logic [3:0] arcache_o,
	output logic [2:0] arprot_o,
	output logic arvalid_o,
	input  logic arready_i,
	output logic [`CACHE_ADDR_W-1:0] awaddr_o,
	output logic [7:0] awlen_o,
	output logic [2:0] awsize_o,
	output logic [1:0] awburst_o,
	output logic [3:0] awcache_o,
	output logic [2:0] awprot_o,
	output logic awvalid_o,
	input  logic awready_i,
	output logic [`CACHE_DATA_W-1:0] wdata_o,
	output logic [STRB_W-1:0] wstrb_o,
	output logic wlast_o,
	output logic wvalid_o,
	input  logic wready_i,
	input  logic [`CACHE_DATA_W-1:0] rdata_i,
	input  logic [1:0] rresp_i,
	input  logic rlast_i,
	input  logic rvalid_i,
	output logic rready_o,
	input  logic [1:0] bresp_i,
	input  logic bvalid_i,
	output logic bready_o
);

	logic [PORT_NUM-1:0] arb_sel;
	logic take;
	logic wb_valid;
	logic wb_ready;
	wbeat_t wb_beat;

	rr_arbiter #(.REQ_NUM(PORT_NUM)) u_arb (
		.clk,
		.rst_n,
		.req_i(req_valid_i),
		.take_i(take),
		.sel_o(arb_sel)
	);

	axi_converter #(.PORT_NUM(PORT_NUM)) u_conv (
		.clk,
		.rst_n,
		.req_valid_i, .req_write_i, .req_burst_i, .req_cached_i, .req_addr_i,
		.wdata_ok_i, .wdata_last_i, .wstrb_i, .wdata_i,
		.req_ready_o, .data_ok_o, .data_last_o, .rdata_o, .resp_o,
		.arb_sel_i(arb_sel),
		.take_o(take),
		.wb_valid_o(wb_valid),
		.wb_ready_i(wb_ready),
		.wb_beat_o(wb_beat),
		.araddr_o, .arlen_o, .arsize_o, .arburst_o, .arcache_o, .arprot_o,
		.arvalid_o, .arready_i,
		.awaddr_o, .awlen_o, .awsize_o, .awburst_o, .awcache_o, .awprot_o,
		.awvalid_o, .awready_i,
		.rdata_i, .rresp_i, .rlast_i, .rvalid_i, .rready_o,
		.bresp_i, .bvalid_i, .bready_o
	);

	axi_wbeat_stage u_wstage (
		.clk,
		.rst_n,
		.in_valid_i(wb_valid),
		.in_ready_o(wb_ready),
		.in_beat_i(wb_beat),
		.wvalid_o,
		.wready_i,
		.wdata_o,
		.wstrb_o,
		.wlast_o
	);

endmodule

/* testbench/axi_mem_model.sv */
`timescale 1ns/1ps
`include "cache_bus_macros.svh"

module axi_mem_model #(
	parameter logic [31:0] FILL_OFS = 32'h0
)(
	input  logic clk,
	input  logic rst_n,
	input  logic [`CACHE_ADDR_W-1:0] araddr_i,
	input  logic [7:0] arlen_i,
	input  logic arvalid_i,
	output logic arready_o,
	input  logic [`CACHE_ADDR_W-1:0] awaddr_i,
	input  logic awvalid_i,
	output logic awready_o,
	input  logic [`CACHE_DATA_W-1:0] wdata_i,
	input  logic [`CACHE_DATA_W/8-1:0] wstrb_i,
	input  logic wlast_i,
	input  logic wvalid_i,
	output logic wready_o,
	output logic [`CACHE_DATA_W-1:0] rdata_o,
	output logic [1:0] rresp_o,
	output logic rlast_o,
	output logic rvalid_o,
	input  logic rready_i,
	output logic [1:0] bresp_o,
	output logic bvalid_o,
	input  logic bready_i
);

	logic [`CACHE_DATA_W-1:0] mem [0:255];
	int seed = 19;
	logic rd_busy, wr_busy;
	logic [31:0] rd_addr, wr_addr;
	logic [7:0] rd_len, rd_cnt, wr_cnt;

	function automatic logic coin();
		int r;
		r = $random(seed);
		return r[0];
	endfunction

	// beat address wraps inside the 16 byte block
	function automatic logic [7:0] beat_idx(input logic [31:0] addr, input int beat);
		logic [31:0] a;
		a = (addr & ~32'hf) | ((addr + 32'(beat) * 32'd4) & 32'hf);
		return a[9:2];
	endfunction

	initial begin
		for (int i = 0; i < 256; i++) begin
			mem[i] = 32'(i) + FILL_OFS;
		end
	end

	assign rresp_o = 2'b00;
	assign bresp_o = 2'b00;

	always @(posedge clk) begin
		if (~rst_n) begin
			arready_o <= 1'b0;
			awready_o <= 1'b0;
			wready_o <= 1'b0;
			rvalid_o <= 1'b0;
			rlast_o <= 1'b0;
			bvalid_o <= 1'b0;
			rd_busy <= 1'b0;
			wr_busy <= 1'b0;
		end else begin
			if (arvalid_i && arready_o) begin
				rd_busy <= 1'b1;
				rd_addr <= araddr_i;
				rd_len <= arlen_i;
				rd_cnt <= 8'd0;
				arready_o <= 1'b0;
			end else begin
				arready_o <= ~rd_busy & coin();
			end
			if (rvalid_o && rready_i) begin
				rvalid_o <= 1'b0;
				if (rlast_o) begin
					rd_busy <= 1'b0;
				end
				rd_cnt <= rd_cnt + 8'd1;
			end else if (rd_busy && !rvalid_o && coin()) begin
				rvalid_o <= 1'b1; // gaps between beats
				rdata_o <= mem[beat_idx(rd_addr, int'(rd_cnt))];
				rlast_o <= (rd_cnt == rd_len);
			end
			if (awvalid_i && awready_o) begin
				wr_busy <= 1'b1;
				wr_addr <= awaddr_i;
				wr_cnt <= 8'd0;
				awready_o <= 1'b0;
			end else begin
				awready_o <= ~wr_busy & ~bvalid_o & coin();
			end
			wready_o <= wr_busy & coin();
			if (wvalid_i && wready_o) begin
				for (int b = 0; b < `CACHE_DATA_W / 8; b++) begin
					if (wstrb_i[b]) begin
						mem[beat_idx(wr_addr, int'(wr_cnt))][8*b +: 8] <= wdata_i[8*b +: 8];
					end
				end
				wr_cnt <= wr_cnt + 8'd1;
				if (wlast_i) begin
					wr_busy <= 1'b0;
					wready_o <= 1'b0;
					bvalid_o <= 1'b1;
				end
			end
			if (bvalid_o && bready_i) begin
				bvalid_o <= 1'b0;
			end
		end
	end

endmodule

/* testbench/cache_axi_sva.sv */
`timescale 1ns/1ps
`include "cache_bus_macros.svh"

module cache_axi_sva
	import cache_bus_pkg::*;
(
	input  logic clk,
	input  logic rst_n,
	input  logic arvalid_i,
	input  logic arready_i,
	input  logic [`CACHE_ADDR_W-1:0] araddr_i,
	input  logic awvalid_i,
	input  logic awready_i,
	input  logic [`CACHE_ADDR_W-1:0] awaddr_i,
	input  logic take_i,
	input  logic [`CACHE_PORT_NUM-1:0] req_ready_i,
	input  bridge_state_t state_i
);

	ar_hold: assert property (@(posedge clk) disable iff (~rst_n)
		arvalid_i && !arready_i |=> arvalid_i && $stable(araddr_i))
		else $error("arvalid or araddr changed before arready");

	aw_hold: assert property (@(posedge clk) disable iff (~rst_n)
		awvalid_i && !awready_i |=> awvalid_i && $stable(awaddr_i))
		else $error("awvalid or awaddr changed before awready");

	one_grant: assert property (@(posedge clk) disable iff (~rst_n)
		take_i |-> $onehot0(req_ready_i))
		else $error("more than one port granted");

	state_onehot: assert property (@(posedge clk) disable iff (~rst_n)
		$onehot(state_i))
		else $error("converter state not one hot");

endmodule

bind axi_converter cache_axi_sva sva_inst (
	.clk(clk), .rst_n(rst_n),
	.arvalid_i(arvalid_o), .arready_i(arready_i), .araddr_i(araddr_o),
	.awvalid_i(awvalid_o), .awready_i(awready_i), .awaddr_i(awaddr_o),
	.take_i(take_o), .req_ready_i(req_ready_o), .state_i(state_q)
);

/* testbench/tb_cache_axi.sv */
`timescale 1ns/1ps
`include "cache_bus_macros.svh"

module tb_cache_axi
	import cache_bus_pkg::*;
;

	localparam int PN = `CACHE_PORT_NUM;
	localparam int DW = `CACHE_DATA_W;
	localparam logic [31:0] FILL_OFS = 32'h3c00_0000;
	localparam int TXN_NUM = 12;
	localparam int CYCLE_LIMIT = TXN_NUM * 64;

	logic clk, rst_n;
	logic [PN-1:0] req_valid, req_write, req_burst, req_cached;
	logic [PN-1:0][`CACHE_ADDR_W-1:0] req_addr;
	logic [PN-1:0] wdata_ok, wdata_last;
	logic [PN-1:0][STRB_W-1:0] wstrb;
	logic [PN-1:0][DW-1:0] wdata;
	logic [PN-1:0] req_ready, data_ok, data_last;
	logic [PN-1:0][DW-1:0] rdata;
	logic [PN-1:0][1:0] resp;
	logic [`CACHE_ADDR_W-1:0] araddr, awaddr;
	logic [7:0] arlen, awlen;
	logic [2:0] arsize, awsize, arprot, awprot;
	logic [1:0] arburst, awburst, rresp, bresp;
	logic [3:0] arcache, awcache;
	logic arvalid, arready, awvalid, awready, wvalid, wready, wlast;
	logic rvalid, rready, rlast, bvalid, bready;
	logic [DW-1:0] axi_wdata, axi_rdata;
	logic [STRB_W-1:0] axi_wstrb;

	logic [DW-1:0] shadow [0:255];
	int error_cnt = 0;
	int cycles = 0;
	int grant_log[$];

	cache_axi_top cache_axi_top_inst (
		.clk, .rst_n,
		.req_valid_i(req_valid), .req_write_i(req_write), .req_burst_i(req_burst),
		.req_cached_i(req_cached), .req_addr_i(req_addr), .wdata_ok_i(wdata_ok),
		.wdata_last_i(wdata_last), .wstrb_i(wstrb), .wdata_i(wdata),
		.req_ready_o(req_ready), .data_ok_o(data_ok), .data_last_o(data_last),
		.rdata_o(rdata), .resp_o(resp),
		.araddr_o(araddr), .arlen_o(arlen), .arsize_o(arsize), .arburst_o(arburst),
		.arcache_o(arcache), .arprot_o(arprot), .arvalid_o(arvalid), .arready_i(arready),
		.awaddr_o(awaddr), .awlen_o(awlen), .awsize_o(awsize), .awburst_o(awburst),
		.awcache_o(awcache), .awprot_o(awprot), .awvalid_o(awvalid), .awready_i(awready),
		.wdata_o(axi_wdata), .wstrb_o(axi_wstrb), .wlast_o(wlast), .wvalid_o(wvalid),
		.wready_i(wready), .rdata_i(axi_rdata), .rresp_i(rresp), .rlast_i(rlast),
		.rvalid_i(rvalid), .rready_o(rready), .bresp_i(bresp), .bvalid_i(bvalid),
		.bready_o(bready)
	);

	axi_mem_model #(.FILL_OFS(FILL_OFS)) mem_inst (
		.clk, .rst_n,
		.araddr_i(araddr), .arlen_i(arlen), .arvalid_i(arvalid), .arready_o(arready),
		.awaddr_i(awaddr), .awvalid_i(awvalid), .awready_o(awready),
		.wdata_i(axi_wdata), .wstrb_i(axi_wstrb), .wlast_i(wlast), .wvalid_i(wvalid),
		.wready_o(wready), .rdata_o(axi_rdata), .rresp_o(rresp), .rlast_o(rlast),
		.rvalid_o(rvalid), .rready_i(rready), .bresp_o(bresp), .bvalid_o(bvalid),
		.bready_i(bready)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout, run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	task automatic check_data(input string name, input logic [DW-1:0] exp, input logic [DW-1:0] act);
		if (exp !== act) begin
			error_cnt++;
			$display("Error at %0t: %s expected %h got %h", $time, name, exp, act);
		end
	endtask

	task automatic check_last(input string name, input logic exp, input logic act);
		if (exp !== act) begin
			error_cnt++;
			$display("Error at %0t: %s expected %b got %b", $time, name, exp, act);
		end
	endtask

	task automatic check_resp(input string name, input logic [1:0] exp, input logic [1:0] act);
		if (exp !== act) begin
			error_cnt++;
			$display("Error at %0t: %s expected %b got %b", $time, name, exp, act);
		end
	endtask

	task automatic check_attr(input string name, input logic [7:0] exp, input logic [7:0] act);
		if (exp !== act) begin
			error_cnt++;
			$display("Error at %0t: %s expected %h got %h", $time, name, exp, act);
		end
	endtask

	// wrap order inside the 16 byte line
	function automatic logic [7:0] word_index(input logic [31:0] addr, input int beat);
		logic [31:0] a;
		a = (addr & ~32'hf) | ((addr + 32'(beat) * 32'd4) & 32'hf);
		return a[9:2];
	endfunction

	// address channel one cycle after the grant
	task automatic check_addr_phase(input logic wr, input logic burst, input logic [31:0] addr);
		logic [7:0] len;
		logic [3:0] cache;
		len = burst ? 8'd3 : 8'd0; // 4 beat line or one beat
		cache = burst ? 4'b0010 : 4'b0000;
		check_attr("arvalid", 8'(!wr), 8'(arvalid));
		check_attr("awvalid", 8'(wr), 8'(awvalid));
		if (wr) begin
			check_data("awaddr", addr, awaddr);
			check_attr("awlen", len, awlen);
			check_attr("awsize", 8'd2, 8'(awsize));
			check_attr("awburst", 8'd2, 8'(awburst));
			check_attr("awcache", 8'(cache), 8'(awcache));
			check_attr("awprot", 8'd1, 8'(awprot));
		end else begin
			check_data("araddr", addr, araddr);
			check_attr("arlen", len, arlen);
			check_attr("arsize", 8'd2, 8'(arsize));
			check_attr("arburst", 8'd2, 8'(arburst));
			check_attr("arcache", 8'(cache), 8'(arcache));
			check_attr("arprot", 8'd1, 8'(arprot));
		end
	endtask

	// hold the request until this port is granted
	task automatic request(input int p, input logic wr, input logic burst, input logic [31:0] addr);
		req_valid[p] = 1'b1;
		req_write[p] = wr;
		req_burst[p] = burst;
		req_cached[p] = burst; // line fills cacheable, single beats not
		req_addr[p] = addr;
		#1;
		while (!req_ready[p]) begin
			@(negedge clk);
			#1;
		end
		grant_log.push_back(p);
		@(negedge clk);
		req_valid[p] = 1'b0;
		check_addr_phase(wr, burst, addr);
	endtask

	task automatic do_read(input int p, input logic [31:0] addr, input logic burst);
		int n, got;
		n = burst ? 4 : 1;
		got = 0;
		request(p, 1'b0, burst, addr);
		while (got < n) begin
			#1;
			if (data_ok[1-p]) begin
				error_cnt++;
				$display("data_ok raised on port %0d during a port %0d read", 1 - p, p);
			end
			if (data_ok[p]) begin
				check_data($sformatf("rdata[%0d]", p), shadow[word_index(addr, got)], rdata[p]);
				check_last($sformatf("data_last[%0d]", p), got == n - 1, data_last[p]);
				check_resp($sformatf("resp[%0d]", p), AXI_RESP_OKAY, resp[p]);
				got++;
			end
			@(negedge clk);
		end
	endtask

	task automatic do_write(input int p, input logic [31:0] addr, input logic burst,
			input logic [31:0] data0, input logic [3:0] strb);
		int n, k;
		logic [7:0] idx;
		n = burst ? 4 : 1;
		k = 0;
		request(p, 1'b1, burst, addr);
		while (k < n) begin
			wdata_ok[p] = 1'b1;
			wdata[p] = data0 + 32'(k);
			wstrb[p] = strb;
			wdata_last[p] = (k == n - 1);
			#1;
			if (data_ok[p]) begin
				idx = word_index(addr, k);
				for (int b = 0; b < STRB_W; b++) begin
					if (strb[b]) begin
						shadow[idx][8*b +: 8] = wdata[p][8*b +: 8];
					end
				end
				k++;
			end
			@(negedge clk);
		end
		wdata_ok[p] = 1'b0;
		#1;
		while (!(bvalid && bready)) begin
			@(negedge clk);
			#1;
		end
		check_resp($sformatf("resp[%0d]", p), AXI_RESP_OKAY, resp[p]);
		@(negedge clk);
	endtask

	task automatic idle_outputs_low();
		repeat (4) begin
			#1;
			if (arvalid || awvalid || wvalid || |data_ok) begin
				error_cnt++;
				$display("AXI valid or data_ok high with no request after reset");
			end
			@(negedge clk);
		end
	endtask

	task automatic arbitration_rounds();
		grant_log.delete();
		fork
			repeat (3) do_read(0, 32'h0000_0080, 1'b1);
			repeat (3) do_read(1, 32'h0000_00c4, 1'b0);
		join
		for (int i = 1; i < grant_log.size(); i++) begin
			if (grant_log[i] == grant_log[i-1]) begin
				error_cnt++;
				$display("port %0d granted twice in a row with both ports requesting", grant_log[i]);
			end
		end
	endtask

	initial begin
		for (int i = 0; i < 256; i++) begin
			shadow[i] = 32'(i) + FILL_OFS;
		end
		rst_n = 1'b0;
		req_valid = '0;
		req_write = '0;
		req_burst = '0;
		req_cached = '0;
		req_addr = '0;
		wdata_ok = '0;
		wdata_last = '0;
		wstrb = '0;
		wdata = '0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		idle_outputs_low();
		do_read(0, 32'h0000_0010, 1'b0);
		do_read(0, 32'h0000_0048, 1'b1);
		do_write(1, 32'h0000_0024, 1'b0, 32'ha5b6_c7d8, 4'b0101);
		do_read(1, 32'h0000_0024, 1'b0);
		do_write(0, 32'h0000_0064, 1'b1, 32'h1234_5670, 4'b1111);
		do_read(0, 32'h0000_0064, 1'b1);
		arbitration_rounds();

		$display("errors: %0d", error_cnt);
		if (error_cnt == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

/* sources.f */
+incdir+include
verilog/cache_bus_pkg.sv
verilog/rr_arbiter.sv
verilog/axi_wbeat_stage.sv
verilog/axi_converter.sv
verilog/cache_axi_top.sv
testbench/axi_mem_model.sv
testbench/cache_axi_sva.sv
testbench/tb_cache_axi.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= tb_cache_axi
FILELIST  ?= sources.f
SIM       := obj_dir/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

$(SIM): $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

test: $(SIM)
	@out=$$(./$(SIM)); echo "$$out"; echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf obj_dir
